// File: source/bridge_defines.svh
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// register banks behind the decoder.
`define BANK_COUNT 4

// words held by each bank.
`define BANK_WORDS 16

// word offset field, at the bottom of the address.
`define OFFSET_LSB 0
`define OFFSET_BITS 4

// bank select field, directly above the offset.
`define BANK_LSB (`OFFSET_LSB + `OFFSET_BITS)
`define BANK_BITS 2

// address bits at or above this position must be zero.
`define MAP_BITS (`OFFSET_BITS + `BANK_BITS)

`endif

// File: source/as_proto_pkg.sv
package as_proto_pkg;

  // one byte on the serial link.
  typedef logic [7:0] byte_t;

  // command codes sent by the host.
  typedef enum logic [7:0] {
    CMD_NOP   = 8'd0,
    CMD_READ  = 8'd1,
    CMD_WRITE = 8'd2,
    CMD_PING  = 8'd8
  } cmd_e;

  // response type byte, first byte of every response frame.
  typedef enum logic [7:0] {
    RESP_ACK      = 8'd1,
    RESP_PING     = 8'd8,
    RESP_CMDERROR = 8'd253,
    RESP_BUSERROR = 8'd254
  } resp_e;

endpackage

// File: source/wb_map_pkg.sv
`include "bridge_defines.svh"

package wb_map_pkg;

  // wishbone data word.
  typedef logic [15:0] word_t;

  // wishbone byte-link address, two bytes from the host.
  typedef logic [15:0] addr_t;

  // bank select and word offset fields of the address.
  typedef logic [`BANK_BITS-1:0] bank_idx_t;
  typedef logic [`OFFSET_BITS-1:0] offset_t;

endpackage

// File: source/as_wb_bridge.sv
module as_wb_bridge (
  input  logic                clk,
  input  logic                reset,
  input  as_proto_pkg::byte_t as_data_i,
  input  logic                as_dstrb_i,
  output logic                as_busy_o,
  output as_proto_pkg::byte_t as_data_o,
  output logic                as_dstrb_o,
  input  logic                as_busy_i,
  output logic                wb_we_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output wb_map_pkg::addr_t   wb_adr_o,
  output wb_map_pkg::word_t   wb_dat_o,
  input  wb_map_pkg::word_t   wb_dat_i,
  input  logic                wb_ack_i,
  input  logic                wb_err_i
);

  typedef enum logic [1:0] {
    ST_COMMAND,
    ST_COLLECT,
    ST_WAIT,
    ST_RESPONSE
  } state_t;

  state_t state;

  as_proto_pkg::byte_t cmd_type;
  wb_map_pkg::addr_t   cmd_addr;
  wb_map_pkg::word_t   cmd_data;
  logic [1:0]          collect_cnt;
  logic                wb_strb;
  logic                datai_take;

  as_proto_pkg::resp_e resp_type;
  wb_map_pkg::word_t   resp_data;

  // response serializer state.
  logic                resp_active;
  logic [1:0]          resp_cnt;
  logic                resp_long;
  as_proto_pkg::resp_e resp_type_buf;
  wb_map_pkg::word_t   resp_data_buf;

  assign as_busy_o  = (state == ST_WAIT) || (state == ST_RESPONSE) || resp_active;
  assign datai_take = as_dstrb_i && !as_busy_o;

  always_ff @(posedge clk) begin
    // the bus strobe is a single-cycle pulse.
    wb_strb <= 1'b0;
    if (reset) begin
      state       <= ST_COMMAND;
      collect_cnt <= '0;
    end else begin
      case (state)
        ST_COMMAND: begin
          collect_cnt <= '0;
          if (datai_take) begin
            cmd_type <= as_data_i;
            case (as_data_i)
              as_proto_pkg::CMD_NOP: begin
                // nothing to answer, stay for the next command.
              end
              as_proto_pkg::CMD_READ, as_proto_pkg::CMD_WRITE: begin
                state <= ST_COLLECT;
              end
              as_proto_pkg::CMD_PING: begin
                resp_type <= as_proto_pkg::RESP_PING;
                state     <= ST_RESPONSE;
              end
              default: begin
                resp_type <= as_proto_pkg::RESP_CMDERROR;
                state     <= ST_RESPONSE;
              end
            endcase
          end
        end
        ST_COLLECT: begin
          if (datai_take) begin
            collect_cnt <= collect_cnt + 2'd1;
            case (collect_cnt)
              2'd0: cmd_addr[7:0] <= as_data_i;
              2'd1: begin
                cmd_addr[15:8] <= as_data_i;
                if (cmd_type == as_proto_pkg::CMD_READ) begin
                  wb_strb <= 1'b1;
                  state   <= ST_WAIT;
                end
              end
              2'd2: cmd_data[7:0] <= as_data_i;
              default: begin
                cmd_data[15:8] <= as_data_i;
                wb_strb        <= 1'b1;
                state          <= ST_WAIT;
              end
            endcase
          end
        end
        ST_WAIT: begin
          if (wb_err_i) begin
            resp_type <= as_proto_pkg::RESP_BUSERROR;
            state     <= ST_RESPONSE;
          end else if (wb_ack_i) begin
            resp_type <= as_proto_pkg::RESP_ACK;
            resp_data <= wb_dat_i;
            state     <= ST_RESPONSE;
          end
        end
        default: begin
          // the serializer takes the response in this same cycle.
          if (!resp_active) begin
            state <= ST_COMMAND;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_active <= 1'b0;
      resp_cnt    <= '0;
    end else if (!resp_active) begin
      resp_cnt <= '0;
      if (state == ST_RESPONSE) begin
        resp_type_buf <= resp_type;
        resp_data_buf <= resp_data;
        resp_long     <= (cmd_type == as_proto_pkg::CMD_READ) &&
                         (resp_type == as_proto_pkg::RESP_ACK);
        resp_active   <= 1'b1;
      end
    end else if (!as_busy_i) begin
      resp_cnt <= resp_cnt + 2'd1;
      if (!resp_long || resp_cnt == 2'd2) begin
        resp_active <= 1'b0;
      end
    end
  end

  // type byte, then data low and high for an acked read.
  always_comb begin
    case (resp_cnt)
      2'd0:    as_data_o = resp_type_buf;
      2'd1:    as_data_o = resp_data_buf[7:0];
      default: as_data_o = resp_data_buf[15:8];
    endcase
  end

  assign as_dstrb_o = resp_active;

  assign wb_cyc_o = wb_strb;
  assign wb_stb_o = wb_strb;
  assign wb_we_o  = cmd_type == as_proto_pkg::CMD_WRITE;
  assign wb_adr_o = cmd_addr;
  assign wb_dat_o = cmd_data;

  a_ack_err_excl: assert property (@(posedge clk) disable iff (reset)
    !(wb_ack_i && wb_err_i));

  // a strobe only enters the wait state, and the slave answers one cycle later.
  a_stb_answer: assert property (@(posedge clk) disable iff (reset)
    wb_stb_o |-> (state == ST_WAIT) ##1 (wb_ack_i || wb_err_i));

endmodule

// File: source/wb_bank_decoder.sv
`include "bridge_defines.svh"

module wb_bank_decoder (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wb_stb_i,
  input  wb_map_pkg::addr_t     wb_adr_i,
  output logic [`BANK_COUNT-1:0] bank_stb_o,
  output wb_map_pkg::offset_t   bank_offset_o,
  output logic                  wb_err_o
);

  wb_map_pkg::bank_idx_t bank_idx;
  logic                  mapped;

  assign bank_idx      = wb_adr_i[`BANK_LSB +: `BANK_BITS];
  assign bank_offset_o = wb_adr_i[`OFFSET_LSB +: `OFFSET_BITS];

  // anything above the bank field makes the address unmapped.
  assign mapped = (wb_adr_i >> `MAP_BITS) == '0;

  always_comb begin
    for (int i = 0; i < `BANK_COUNT; i++) begin
      bank_stb_o[i] = wb_stb_i && mapped && (bank_idx == wb_map_pkg::bank_idx_t'(i));
    end
  end

  // error lines up with the registered bank acknowledge.
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_err_o <= 1'b0;
    end else begin
      wb_err_o <= wb_stb_i && !mapped;
    end
  end

  a_stb_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(bank_stb_o));

endmodule

// File: source/wb_reg_bank.sv
`include "bridge_defines.svh"

module wb_reg_bank (
  input  logic                clk,
  input  logic                reset,
  input  logic                stb_i,
  input  logic                we_i,
  input  wb_map_pkg::offset_t offset_i,
  input  wb_map_pkg::word_t   dat_i,
  output wb_map_pkg::word_t   dat_o,
  output logic                ack_o
);

  wb_map_pkg::word_t regs [`BANK_WORDS];

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_o <= 1'b0;
      for (int i = 0; i < `BANK_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      ack_o <= stb_i;
      if (stb_i && we_i) begin
        regs[offset_i] <= dat_i;
      end
    end
  end

  // read data rides along with the ack.
  always_ff @(posedge clk) begin
    if (stb_i && !we_i) begin
      dat_o <= regs[offset_i];
    end
  end

  a_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
    ack_o |-> $past(stb_i));

endmodule

// File: source/wb_bank_return.sv
`include "bridge_defines.svh"

module wb_bank_return (
  input  logic [`BANK_COUNT-1:0] bank_ack_i,
  input  wb_map_pkg::word_t      bank_dat_i [`BANK_COUNT],
  output logic                   wb_ack_o,
  output wb_map_pkg::word_t      wb_dat_o
);

  assign wb_ack_o = |bank_ack_i;

  // acks are one-hot, so an and-or mux picks the acking bank.
  always_comb begin
    wb_dat_o = '0;
    for (int i = 0; i < `BANK_COUNT; i++) begin
      if (bank_ack_i[i]) begin
        wb_dat_o = wb_dat_o | bank_dat_i[i];
      end
    end
  end

endmodule

// File: source/as_wb_top.sv
`include "bridge_defines.svh"

module as_wb_top (
  input  logic                clk,
  input  logic                reset,
  input  as_proto_pkg::byte_t as_data_i,
  input  logic                as_dstrb_i,
  output logic                as_busy_o,
  output as_proto_pkg::byte_t as_data_o,
  output logic                as_dstrb_o,
  input  logic                as_busy_i
);

  logic                   wb_we;
  logic                   wb_cyc;
  logic                   wb_stb;
  wb_map_pkg::addr_t      wb_adr;
  wb_map_pkg::word_t      wb_dat_m2s;
  wb_map_pkg::word_t      wb_dat_s2m;
  logic                   wb_ack;
  logic                   wb_err;
  logic [`BANK_COUNT-1:0] bank_stb;
  logic [`BANK_COUNT-1:0] bank_ack;
  wb_map_pkg::offset_t    bank_offset;
  wb_map_pkg::word_t      bank_dat [`BANK_COUNT];

  as_wb_bridge u_bridge (
    .clk        (clk),
    .reset      (reset),
    .as_data_i  (as_data_i),
    .as_dstrb_i (as_dstrb_i),
    .as_busy_o  (as_busy_o),
    .as_data_o  (as_data_o),
    .as_dstrb_o (as_dstrb_o),
    .as_busy_i  (as_busy_i),
    .wb_we_o    (wb_we),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_adr_o   (wb_adr),
    .wb_dat_o   (wb_dat_m2s),
    .wb_dat_i   (wb_dat_s2m),
    .wb_ack_i   (wb_ack),
    .wb_err_i   (wb_err)
  );

  // a slave is selected only inside a bus cycle.
  wb_bank_decoder u_decoder (
    .clk           (clk),
    .reset         (reset),
    .wb_stb_i      (wb_cyc & wb_stb),
    .wb_adr_i      (wb_adr),
    .bank_stb_o    (bank_stb),
    .bank_offset_o (bank_offset),
    .wb_err_o      (wb_err)
  );

  for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_bank
    wb_reg_bank u_bank (
      .clk      (clk),
      .reset    (reset),
      .stb_i    (bank_stb[g]),
      .we_i     (wb_we),
      .offset_i (bank_offset),
      .dat_i    (wb_dat_m2s),
      .dat_o    (bank_dat[g]),
      .ack_o    (bank_ack[g])
    );
  end

  wb_bank_return u_return (
    .bank_ack_i (bank_ack),
    .bank_dat_i (bank_dat),
    .wb_ack_o   (wb_ack),
    .wb_dat_o   (wb_dat_s2m)
  );

endmodule

// File: tb/tb_as_wb_top.sv
module tb_as_wb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  localparam int CYCLES_PER_CASE = 200;
  localparam int MAX_CASES = 64;
  localparam logic [31:0] LFSR_SEED = 32'h8496_ccff;

  logic                clk;
  logic                reset;
  as_proto_pkg::byte_t as_data_i;
  logic                as_dstrb_i;
  logic                as_busy_o;
  as_proto_pkg::byte_t as_data_o;
  logic                as_dstrb_o;
  logic                as_busy_i;

  logic [7:0]  case_cmd [MAX_CASES];
  logic [15:0] case_addr [MAX_CASES];
  logic [15:0] case_data [MAX_CASES];
  int          case_nresp [MAX_CASES];
  logic [7:0]  case_resp [MAX_CASES][3];
  int          num_cases;
  int          errors;
  int          cycles;
  int          cycle_limit;
  logic [31:0] lfsr;
  logic [7:0]  rx_bytes [$];

  as_wb_top u_as_wb_top (
    .clk        (clk),
    .reset      (reset),
    .as_data_i  (as_data_i),
    .as_dstrb_i (as_dstrb_i),
    .as_busy_o  (as_busy_o),
    .as_data_o  (as_data_o),
    .as_dstrb_o (as_dstrb_o),
    .as_busy_i  (as_busy_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic compare_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // called at a rising edge, returns at the edge that takes the byte.
  task automatic send_byte(input logic [7:0] b);
    as_data_i  <= b;
    as_dstrb_i <= 1'b1;
    @(negedge clk);
    while (as_busy_o) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (as_busy_o || as_dstrb_o) @(negedge clk);
    @(posedge clk);
  endtask

  // one busy bit per cycle on the response link.
  initial begin
    lfsr      = LFSR_SEED;
    as_busy_i = 1'b0;
    forever begin
      @(posedge clk);
      as_busy_i <= !reset && lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  end

  // a byte leaves the bridge in a cycle with the strobe up and no back-pressure.
  always @(negedge clk) begin
    if (as_dstrb_o && !as_busy_i) begin
      rx_bytes.push_back(as_data_o);
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout: run still going after %0d cycles", cycles);
        $display("cases run: %0d, errors: %0d", num_cases, errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
      end
    end
  end

  initial begin
    int    fd;
    int    n;
    int    base;
    int    got;
    int    cmd, addr, data, nresp, r0, r1, r2;
    string line;
    reset      = 1'b1;
    as_data_i  = '0;
    as_dstrb_i = 1'b0;
    errors     = 0;
    num_cases  = 0;
    fd = $fopen("tb/as_wb_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file tb/as_wb_cases.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0 && num_cases < MAX_CASES) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %d %h %h %h", cmd, addr, data, nresp, r0, r1, r2);
          if (n != 7) begin
            $display("malformed case line: %s", line);
            errors++;
          end else begin
            case_cmd[num_cases]     = cmd[7:0];
            case_addr[num_cases]    = addr[15:0];
            case_data[num_cases]    = data[15:0];
            case_nresp[num_cases]   = nresp;
            case_resp[num_cases][0] = r0[7:0];
            case_resp[num_cases][1] = r1[7:0];
            case_resp[num_cases][2] = r2[7:0];
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
    if (num_cases == 0) begin
      $display("no cases were read from the case file");
      errors++;
    end
    cycle_limit = CYCLES_PER_CASE * num_cases + 16;

    repeat (3) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < num_cases; i++) begin
      base = rx_bytes.size();
      send_byte(case_cmd[i]);
      if (case_cmd[i] == as_proto_pkg::CMD_READ || case_cmd[i] == as_proto_pkg::CMD_WRITE) begin
        send_byte(case_addr[i][7:0]);
        send_byte(case_addr[i][15:8]);
      end
      if (case_cmd[i] == as_proto_pkg::CMD_WRITE) begin
        send_byte(case_data[i][7:0]);
        send_byte(case_data[i][15:8]);
      end
      as_dstrb_i <= 1'b0;
      wait_idle();
      got = rx_bytes.size() - base;
      if (got != case_nresp[i]) begin
        $display("case %0d: expected %0d response bytes but received %0d",
                 i, case_nresp[i], got);
        errors++;
      end
      for (int j = 0; j < got && j < case_nresp[i]; j++) begin
        compare_byte($sformatf("as_data_o[%0d]", j), rx_bytes[base + j], case_resp[i][j]);
      end
    end

    $display("cases run: %0d, errors: %0d", num_cases, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: tb/as_wb_cases.txt
# cmd addr data nresp resp0 resp1 resp2 (hex fields, nresp in decimal)
# addr and data go out low byte first; unused fields are 00
01 0005 0000 3 01 00 00
02 0005 beef 1 01 00 00
02 0015 1234 1 01 00 00
01 0025 0000 3 01 00 00
01 0015 0000 3 01 34 12
02 0045 dead 1 fe 00 00
01 8005 0000 1 fe 00 00
01 0005 0000 3 01 ef be
08 0000 0000 1 08 00 00
55 0000 0000 1 fd 00 00
00 0000 0000 0 00 00 00
02 003f c3c3 1 01 00 00
01 003f 0000 3 01 c3 c3

// File: build.f
+incdir+source
source/as_proto_pkg.sv
source/wb_map_pkg.sv
source/as_wb_bridge.sv
source/wb_bank_decoder.sv
source/wb_reg_bank.sv
source/wb_bank_return.sv
source/as_wb_top.sv
tb/tb_as_wb_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_as_wb_top -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: PASS" sim.log
